// File: jpeg_ff_stuffer.f
rtl/jpeg_stuff_pkg.sv
rtl/ff_detect.sv
rtl/byte_stuffer.sv
rtl/word_packer.sv
rtl/jpeg_ff_stuffer.sv
verif/stuff_checker.sv
verif/tb_jpeg_ff_stuffer.sv

// File: Bender.yml
package:
  name: jpeg_ff_stuffer

sources:
  - rtl/jpeg_stuff_pkg.sv
  - rtl/ff_detect.sv
  - rtl/byte_stuffer.sv
  - rtl/word_packer.sv
  - rtl/jpeg_ff_stuffer.sv
  - target: test
    files:
      - verif/stuff_checker.sv
      - verif/tb_jpeg_ff_stuffer.sv

// File: verif/tb_jpeg_ff_stuffer.sv
`timescale 1ns/10ps
`default_nettype none

module tb_jpeg_ff_stuffer;

    localparam int CLK_PERIOD  = 40;
    localparam int MODE_CLEAN  = 0;
    localparam int MODE_ALL_FF = 1;
    localparam int MODE_MIXED  = 2;

    logic                              clk;
    logic                              rst;
    logic                              data_ready_in;
    logic [jpeg_stuff_pkg::WORD_W-1:0] jpeg_in;
    logic                              end_of_file_signal;
    logic [jpeg_stuff_pkg::WORD_W-1:0] jpeg_bitstream;
    logic                              data_ready;
    logic                              eof_data_partial_ready;
    logic [1:0]                        eof_byte_count;

    int          err_count;
    int          word_count;
    int          flush_count;
    int          queued;
    int          timeouts;
    logic [31:0] rng_state;

    jpeg_ff_stuffer i_dut (
        .clk                    (clk),
        .rst                    (rst),
        .data_ready_in          (data_ready_in),
        .jpeg_in                (jpeg_in),
        .end_of_file_signal     (end_of_file_signal),
        .jpeg_bitstream         (jpeg_bitstream),
        .data_ready             (data_ready),
        .eof_data_partial_ready (eof_data_partial_ready),
        .eof_byte_count         (eof_byte_count)
    );

    stuff_checker i_checker (
        .clk                    (clk),
        .rst                    (rst),
        .data_ready_in          (data_ready_in),
        .jpeg_in                (jpeg_in),
        .end_of_file_signal     (end_of_file_signal),
        .jpeg_bitstream         (jpeg_bitstream),
        .data_ready             (data_ready),
        .eof_data_partial_ready (eof_data_partial_ready),
        .eof_byte_count         (eof_byte_count),
        .err_count              (err_count),
        .word_count             (word_count),
        .flush_count            (flush_count),
        .queued                 (queued)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    // About one byte in three is a marker in mixed mode
    task automatic random_byte(input int mode, output logic [jpeg_stuff_pkg::BYTE_W-1:0] b);
        rng_state = lcg_step(rng_state);
        if (mode == MODE_ALL_FF) begin
            b = jpeg_stuff_pkg::MARKER_BYTE;
        end else if (mode == MODE_MIXED && rng_state[31:24] < 8'd85) begin
            b = jpeg_stuff_pkg::MARKER_BYTE;
        end else begin
            b = rng_state[15:8];
        end
        if (mode == MODE_CLEAN && b == jpeg_stuff_pkg::MARKER_BYTE) begin
            b = 8'hfe;
        end
    endtask

    task automatic send_stream(input int mode, input int count);
        logic [jpeg_stuff_pkg::WORD_W-1:0] w;
        logic [jpeg_stuff_pkg::BYTE_W-1:0] b;
        int                                gap;
        w = '0;
        for (int n = 0; n < count; n++) begin
            for (int i = 0; i < jpeg_stuff_pkg::WORD_BYTES; i++) begin
                random_byte(mode, b);
                w = {w[jpeg_stuff_pkg::WORD_W-jpeg_stuff_pkg::BYTE_W-1:0], b};
            end
            rng_state = lcg_step(rng_state);
            gap = 1 + int'(rng_state[23:16]) % 3;
            data_ready_in = 1'b1;
            jpeg_in       = w;
            wait_cycles(1);
            data_ready_in = 1'b0;
            wait_cycles(gap);
        end
    endtask

    task automatic end_file();
        int n;
        // Pipeline and second word drain before the pulse
        wait_cycles(6);
        n = 0;
        while (queued >= jpeg_stuff_pkg::WORD_BYTES && n < 20) begin
            wait_cycles(1);
            n++;
        end
        if (queued >= jpeg_stuff_pkg::WORD_BYTES) begin
            $display("timeout: full output words still missing before end of file");
            timeouts++;
        end else begin
            end_of_file_signal = 1'b1;
            wait_cycles(1);
            end_of_file_signal = 1'b0;
            n = 0;
            while (queued != 0 && n < 8) begin
                wait_cycles(1);
                n++;
            end
            if (queued != 0) begin
                $display("timeout: flush word did not arrive after end of file");
                timeouts++;
            end
            // Quiet window, any stray word shows up in the checker
            wait_cycles(5);
        end
    endtask

    initial begin
        rng_state          = 32'hc552;
        timeouts           = 0;
        rst                = 1'b1;
        data_ready_in      = 1'b0;
        jpeg_in            = '0;
        end_of_file_signal = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;

        // Outputs must stay idle before any input
        wait_cycles(6);

        send_stream(MODE_CLEAN, 8);
        end_file();
        if (timeouts == 0) begin
            send_stream(MODE_ALL_FF, 6);
            end_file();
        end
        for (int r = 0; r < 8 && timeouts == 0; r++) begin
            send_stream(MODE_MIXED, 5 + 3 * r);
            end_file();
        end

        $display("checked %0d words and %0d flushes, %0d errors, %0d timeouts",
                 word_count, flush_count, err_count, timeouts);
        if (err_count == 0 && timeouts == 0 && word_count > 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/stuff_checker.sv
`timescale 1ns/10ps
`default_nettype none

module stuff_checker (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               data_ready_in,
    input  logic [jpeg_stuff_pkg::WORD_W-1:0]  jpeg_in,
    input  logic                               end_of_file_signal,
    input  logic [jpeg_stuff_pkg::WORD_W-1:0]  jpeg_bitstream,
    input  logic                               data_ready,
    input  logic                               eof_data_partial_ready,
    input  logic [1:0]                         eof_byte_count,
    output int                                 err_count,
    output int                                 word_count,
    output int                                 flush_count,
    output int                                 queued
);

    // Expected output byte stream, oldest byte at the front
    logic [jpeg_stuff_pkg::BYTE_W-1:0] model_q[$];
    logic                              flush_due;
    logic                              had_flush;

    task automatic push_word(input logic [jpeg_stuff_pkg::WORD_W-1:0] w);
        logic [jpeg_stuff_pkg::BYTE_W-1:0] b;
        for (int i = jpeg_stuff_pkg::WORD_BYTES - 1; i >= 0; i--) begin
            b = w[i*jpeg_stuff_pkg::BYTE_W +: jpeg_stuff_pkg::BYTE_W];
            model_q.push_back(b);
            if (b == jpeg_stuff_pkg::MARKER_BYTE) begin
                model_q.push_back(8'h00);
            end
        end
    endtask

    task automatic check_full_word();
        logic [jpeg_stuff_pkg::WORD_W-1:0] expected;
        expected = '0;
        for (int i = 0; i < jpeg_stuff_pkg::WORD_BYTES; i++) begin
            expected = expected << jpeg_stuff_pkg::BYTE_W;
            expected[jpeg_stuff_pkg::BYTE_W-1:0] = model_q.pop_front();
        end
        if (jpeg_bitstream !== expected) begin
            $display("mismatch at %0t: jpeg_bitstream expected %h, got %h",
                     $time, expected, jpeg_bitstream);
            err_count++;
        end
        word_count++;
    endtask

    task automatic check_flush();
        logic [jpeg_stuff_pkg::WORD_W-1:0] expected;
        int                                n;
        n        = model_q.size();
        expected = '0;
        // Remaining bytes left-aligned, zero behind them
        for (int i = 0; i < jpeg_stuff_pkg::WORD_BYTES; i++) begin
            expected = expected << jpeg_stuff_pkg::BYTE_W;
            if (model_q.size() > 0) begin
                expected[jpeg_stuff_pkg::BYTE_W-1:0] = model_q.pop_front();
            end
        end
        if (n < 1 || n >= jpeg_stuff_pkg::WORD_BYTES) begin
            $display("flush word at %0t while %0d bytes were pending", $time, n);
            err_count++;
        end
        if (jpeg_bitstream !== expected) begin
            $display("mismatch at %0t: jpeg_bitstream expected %h, got %h",
                     $time, expected, jpeg_bitstream);
            err_count++;
        end
        if (eof_byte_count !== 2'(n)) begin
            $display("mismatch at %0t: eof_byte_count expected %0d, got %0d",
                     $time, 2'(n), eof_byte_count);
            err_count++;
        end
        model_q.delete();
        flush_count++;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            model_q.delete();
            flush_due   = 1'b0;
            err_count   = 0;
            word_count  = 0;
            flush_count = 0;
        end else begin
            had_flush = flush_due;
            flush_due = 1'b0;

            // Outputs registered on the previous edge
            if (eof_data_partial_ready && !data_ready) begin
                $display("eof_data_partial_ready high without data_ready at %0t", $time);
                err_count++;
            end
            if (data_ready && eof_data_partial_ready) begin
                if (!had_flush) begin
                    $display("flush word at %0t without an end-of-file request", $time);
                    err_count++;
                end
                check_flush();
            end else if (data_ready) begin
                if (model_q.size() < jpeg_stuff_pkg::WORD_BYTES) begin
                    $display("unexpected output word at %0t with only %0d bytes pending",
                             $time, model_q.size());
                    err_count++;
                end else begin
                    check_full_word();
                end
            end else if (had_flush) begin
                $display("no flush word after end of file at %0t", $time);
                err_count++;
            end

            // Inputs sampled on this edge
            if (data_ready_in) begin
                push_word(jpeg_in);
            end
            if (end_of_file_signal && model_q.size() > 0) begin
                flush_due = 1'b1;
            end
        end
        queued = model_q.size();
    end

endmodule

`default_nettype wire

// File: rtl/jpeg_ff_stuffer.sv
`timescale 1ns/10ps
`default_nettype none

module jpeg_ff_stuffer (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               data_ready_in,
    input  logic [jpeg_stuff_pkg::WORD_W-1:0]  jpeg_in,
    input  logic                               end_of_file_signal,
    output logic [jpeg_stuff_pkg::WORD_W-1:0]  jpeg_bitstream,
    output logic                               data_ready,
    output logic                               eof_data_partial_ready,
    output logic [1:0]                         eof_byte_count
);

    logic                                   det_valid;
    logic [jpeg_stuff_pkg::WORD_W-1:0]      det_word;
    logic [jpeg_stuff_pkg::WORD_BYTES-1:0]  det_ff;

    logic                                   stf_valid;
    logic [jpeg_stuff_pkg::STUFFED_W-1:0]   stf_bytes;
    logic [jpeg_stuff_pkg::LEN_W-1:0]       stf_len;

    ff_detect i_ff_detect (
        .clk           (clk),
        .rst           (rst),
        .data_ready_in (data_ready_in),
        .jpeg_in       (jpeg_in),
        .det_valid     (det_valid),
        .det_word      (det_word),
        .det_ff        (det_ff)
    );

    byte_stuffer i_byte_stuffer (
        .clk       (clk),
        .rst       (rst),
        .det_valid (det_valid),
        .det_word  (det_word),
        .det_ff    (det_ff),
        .stf_valid (stf_valid),
        .stf_bytes (stf_bytes),
        .stf_len   (stf_len)
    );

    // End of file bypasses the first two stages
    word_packer i_word_packer (
        .clk                    (clk),
        .rst                    (rst),
        .stf_valid              (stf_valid),
        .stf_bytes              (stf_bytes),
        .stf_len                (stf_len),
        .end_of_file_signal     (end_of_file_signal),
        .jpeg_bitstream         (jpeg_bitstream),
        .data_ready             (data_ready),
        .eof_data_partial_ready (eof_data_partial_ready),
        .eof_byte_count         (eof_byte_count)
    );

endmodule

`default_nettype wire

// File: rtl/word_packer.sv
`timescale 1ns/10ps
`default_nettype none

module word_packer (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  stf_valid,
    input  logic [jpeg_stuff_pkg::STUFFED_W-1:0]  stf_bytes,
    input  logic [jpeg_stuff_pkg::LEN_W-1:0]      stf_len,
    input  logic                                  end_of_file_signal,
    output logic [jpeg_stuff_pkg::WORD_W-1:0]     jpeg_bitstream,
    output logic                                  data_ready,
    output logic                                  eof_data_partial_ready,
    output logic [1:0]                            eof_byte_count
);

    // Pending bytes sit left-aligned with zeros past pend_cnt
    logic [jpeg_stuff_pkg::PEND_BYTES*jpeg_stuff_pkg::BYTE_W-1:0] pend_buf;
    logic [jpeg_stuff_pkg::LEN_W-1:0]                             pend_cnt;
    logic                                                         second_word;

    logic [jpeg_stuff_pkg::PEND_BYTES*jpeg_stuff_pkg::BYTE_W-1:0] merged;
    logic [jpeg_stuff_pkg::PEND_BYTES*jpeg_stuff_pkg::BYTE_W-1:0] new_aligned;
    logic [jpeg_stuff_pkg::LEN_W-1:0]                             total;

    // New bytes go right behind the pending ones
    always_comb begin
        new_aligned = {stf_bytes,
                       {(jpeg_stuff_pkg::PEND_BYTES * jpeg_stuff_pkg::BYTE_W
                         - jpeg_stuff_pkg::STUFFED_W){1'b0}}};
        merged      = pend_buf | (new_aligned >> (int'(pend_cnt) * jpeg_stuff_pkg::BYTE_W));
        total       = pend_cnt + stf_len;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pend_buf               <= '0;
            pend_cnt               <= '0;
            second_word            <= 1'b0;
            data_ready             <= 1'b0;
            eof_data_partial_ready <= 1'b0;
            eof_byte_count         <= '0;
        end else begin
            data_ready             <= 1'b0;
            eof_data_partial_ready <= 1'b0;
            eof_byte_count         <= '0;
            second_word            <= 1'b0;
            if (second_word) begin
                // Rollover word from the previous append
                data_ready <= 1'b1;
                pend_buf   <= pend_buf << jpeg_stuff_pkg::WORD_W;
                pend_cnt   <= pend_cnt - jpeg_stuff_pkg::LEN_W'(jpeg_stuff_pkg::WORD_BYTES);
            end else if (stf_valid) begin
                if (total >= jpeg_stuff_pkg::LEN_W'(jpeg_stuff_pkg::WORD_BYTES)) begin
                    data_ready  <= 1'b1;
                    pend_buf    <= merged << jpeg_stuff_pkg::WORD_W;
                    pend_cnt    <= total - jpeg_stuff_pkg::LEN_W'(jpeg_stuff_pkg::WORD_BYTES);
                    second_word <= (total >=
                                    jpeg_stuff_pkg::LEN_W'(2 * jpeg_stuff_pkg::WORD_BYTES));
                end else begin
                    pend_buf <= merged;
                    pend_cnt <= total;
                end
            end else if (end_of_file_signal && (pend_cnt != '0)) begin
                // Flush of 1 to 3 leftover bytes
                data_ready             <= 1'b1;
                eof_data_partial_ready <= 1'b1;
                eof_byte_count         <= pend_cnt[1:0];
                pend_buf               <= '0;
                pend_cnt               <= '0;
            end
        end
    end

    // Output word is the top of the buffer before or after the append
    always_ff @(posedge clk) begin
        if (second_word) begin
            jpeg_bitstream <= pend_buf[$high(pend_buf) -: jpeg_stuff_pkg::WORD_W];
        end else if (stf_valid) begin
            jpeg_bitstream <= merged[$high(merged) -: jpeg_stuff_pkg::WORD_W];
        end else if (end_of_file_signal) begin
            jpeg_bitstream <= pend_buf[$high(pend_buf) -: jpeg_stuff_pkg::WORD_W];
        end
    end

endmodule

`default_nettype wire

// File: rtl/byte_stuffer.sv
`timescale 1ns/10ps
`default_nettype none

module byte_stuffer (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   det_valid,
    input  logic [jpeg_stuff_pkg::WORD_W-1:0]      det_word,
    input  logic [jpeg_stuff_pkg::WORD_BYTES-1:0]  det_ff,
    output logic                                   stf_valid,
    output logic [jpeg_stuff_pkg::STUFFED_W-1:0]   stf_bytes,
    output logic [jpeg_stuff_pkg::LEN_W-1:0]       stf_len
);

    logic [jpeg_stuff_pkg::STUFFED_W-1:0] stuffed;
    logic [jpeg_stuff_pkg::LEN_W-1:0]     len;
    int                                   pos;

    // Walk the bytes from the top, each one lands at the next free slot
    always_comb begin
        stuffed = '0;
        len     = '0;
        pos     = 0;
        for (int i = jpeg_stuff_pkg::WORD_BYTES - 1; i >= 0; i--) begin
            pos = jpeg_stuff_pkg::STUFFED_W - 1 - int'(len) * jpeg_stuff_pkg::BYTE_W;
            stuffed[pos -: jpeg_stuff_pkg::BYTE_W] =
                det_word[i*jpeg_stuff_pkg::BYTE_W +: jpeg_stuff_pkg::BYTE_W];
            len = len + 1'b1;
            if (det_ff[i]) begin
                // Zero byte right behind the marker
                pos = jpeg_stuff_pkg::STUFFED_W - 1 - int'(len) * jpeg_stuff_pkg::BYTE_W;
                stuffed[pos -: jpeg_stuff_pkg::BYTE_W] = jpeg_stuff_pkg::STUFF_BYTE;
                len = len + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stf_valid <= 1'b0;
        end else begin
            stf_valid <= det_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (det_valid) begin
            stf_bytes <= stuffed;
            stf_len   <= len;
        end
    end

endmodule

`default_nettype wire

// File: rtl/ff_detect.sv
`timescale 1ns/10ps
`default_nettype none

module ff_detect (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   data_ready_in,
    input  logic [jpeg_stuff_pkg::WORD_W-1:0]      jpeg_in,
    output logic                                   det_valid,
    output logic [jpeg_stuff_pkg::WORD_W-1:0]      det_word,
    output logic [jpeg_stuff_pkg::WORD_BYTES-1:0]  det_ff
);

    logic [jpeg_stuff_pkg::WORD_BYTES-1:0] ff_hit;

    // Marker compare per byte, bit 3 is the most significant byte
    always_comb begin
        for (int i = 0; i < jpeg_stuff_pkg::WORD_BYTES; i++) begin
            ff_hit[i] = (jpeg_in[i*jpeg_stuff_pkg::BYTE_W +: jpeg_stuff_pkg::BYTE_W]
                         == jpeg_stuff_pkg::MARKER_BYTE);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            det_valid <= 1'b0;
        end else begin
            det_valid <= data_ready_in;
        end
    end

    // Word and flags move together on the input strobe
    always_ff @(posedge clk) begin
        if (data_ready_in) begin
            det_word <= jpeg_in;
            det_ff   <= ff_hit;
        end
    end

endmodule

`default_nettype wire

// File: rtl/jpeg_stuff_pkg.sv
`default_nettype none

package jpeg_stuff_pkg;

    // Byte and word geometry
    localparam int BYTE_W     = 8;
    localparam int WORD_BYTES = 4;
    localparam int WORD_W     = BYTE_W * WORD_BYTES;

    // JPEG marker escape
    localparam logic [BYTE_W-1:0] MARKER_BYTE = 8'hff;
    localparam logic [BYTE_W-1:0] STUFF_BYTE  = 8'h00;

    // Worst case is every byte of a word being 0xFF
    localparam int MAX_STUFFED_BYTES = 2 * WORD_BYTES;
    localparam int STUFFED_W         = MAX_STUFFED_BYTES * BYTE_W;

    // Holds counts up to MAX_STUFFED_BYTES
    localparam int LEN_W = 4;

    // Up to 3 leftover bytes plus one full stuffed word, rounded to whole words
    localparam int PEND_BYTES = 12;

endpackage

`default_nettype wire
